//--- Makefile
# Verilator build and run for the SPI unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = spiUnitTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- compile.f
src/spiPkg.sv
src/spiClockDivider.sv
src/spiMasterCsr.sv
src/spiMasterByte.sv
src/spiSlaveFrame.sv
src/spiRegBank.sv
src/spiUnit.sv
testbench/spiUnitChecker.sv
testbench/spiUnitTb.sv

//--- src/spiClockDivider.sv
/*
 * Master SCK divider
 * One-cycle tick every divisor plus one clocks while enabled
 */
`default_nettype none
`timescale 1ns/10ps

module spiClockDivider (
	input  logic        iSCLK,
	input  logic        iSRST,
	input  logic        enable,
	input  spiPkg::divT divisor,
	output logic        divTick
);
	import spiPkg::*;

	// Clocks since the last tick
	divT count;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST || !enable)
		begin
			// Idle divider holds at zero so the first tick is a full period away
			count   <= '0;
			divTick <= 1'b0;
		end
		else if (count == divisor)
		begin
			// Terminal count
			count   <= '0;
			divTick <= 1'b1;
		end
		else
		begin
			count   <= count + 8'd1;
			divTick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- src/spiMasterByte.sv
/*
 * SPI master byte engine
 * SCK generation, MOSI with hold after the falling edge,
 * MISO capture on the rising edge and the completion pulse
 */
`default_nettype none
`timescale 1ns/10ps

module spiMasterByte #(
	parameter int pHoldCycles = 2
) (
	input  logic         iSCLK,
	input  logic         iSRST,
	input  logic         enable,
	input  logic         divTick,
	input  spiPkg::byteT txByte,
	input  logic         miso,
	output logic         sck,
	output logic         mosi,
	output logic         byteDone,
	output spiPkg::byteT rxByte
);
	import spiPkg::*;

	localparam int lpHoldW = $clog2(pHoldCycles + 2);
	localparam logic [lpHoldW-1:0] lpHoldMax = lpHoldW'(pHoldCycles);

	logic [3:0]         negCount;
	logic               running;
	logic               tickUse;
	logic               riseTick;
	logic               fallTick;
	logic               loadTx;
	logic               shiftNow;
	logic [lpHoldW-1:0] sinceTick;
	logic [lpHoldW-1:0] holdLeft;
	holdStateT          holdState;
	byteT               txShift;

	// Ticks stop counting after the eighth falling edge
	assign running  = enable && (negCount != 4'd8);
	assign tickUse  = divTick && running;
	assign riseTick = tickUse && !sck;
	assign fallTick = tickUse && sck;

	// Reload until the first SCK edge of a byte
	// CSR updates txByte on the same edge as the enable
	assign loadTx = !enable || ((negCount == 4'd0) && !sck && !divTick);

	assign mosi = txShift[7];

	// --------------------------------------------------
	// SCK and falling edge count
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || !enable)
		begin
			sck      <= 1'b0;
			negCount <= 4'd0;
		end
		else if (tickUse)
		begin
			sck <= ~sck;
			if (sck)
			begin
				negCount <= negCount + 4'd1;
			end
		end
	end

	// Clocks since the last tick, saturating at the hold length
	// At a falling edge this equals the room left before the next rising edge
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || !enable || divTick)
		begin
			sinceTick <= '0;
		end
		else if (sinceTick != lpHoldMax)
		begin
			sinceTick <= sinceTick + lpHoldW'(1);
		end
	end

	// --------------------------------------------------
	// MOSI hold FSM
	// --------------------------------------------------

	// Hold is pHoldCycles clocks, shortened on fast divisors
	// so the next bit still settles before the rising edge
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || !enable)
		begin
			holdState <= holdIdle;
			holdLeft  <= '0;
		end
		else
		begin
			case (holdState)
				holdIdle:
				begin
					if (fallTick && (sinceTick != '0))
					begin
						holdState <= holdActive;
						holdLeft  <= sinceTick;
					end
				end
				holdActive:
				begin
					holdLeft <= holdLeft - lpHoldW'(1);
					if (holdLeft == lpHoldW'(1))
					begin
						holdState <= holdIdle;
					end
				end
				default:
				begin
					holdState <= holdIdle;
				end
			endcase
		end
	end

	// Zero room shifts on the falling edge itself
	assign shiftNow = ((holdState == holdIdle) && fallTick && (sinceTick == '0))
		|| ((holdState == holdActive) && (holdLeft == lpHoldW'(1)));

	// MSB first
	always_ff @(posedge iSCLK)
	begin
		if (loadTx)
		begin
			txShift <= txByte;
		end
		else if (shiftNow)
		begin
			txShift <= {txShift[6:0], 1'b1};
		end
	end

	// --------------------------------------------------
	// MISO capture and completion
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (riseTick)
		begin
			rxByte <= {rxByte[6:0], miso};
		end
	end

	// Eighth falling edge
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			byteDone <= 1'b0;
		end
		else
		begin
			byteDone <= fallTick && (negCount == 4'd7);
		end
	end

endmodule

`default_nettype wire

//--- src/spiMasterCsr.sv
/*
 * SPI master control registers
 * Holds the run enable with the byte and divisor of the current transfer
 */
`default_nettype none
`timescale 1ns/10ps

module spiMasterCsr (
	input  logic         iSCLK,
	input  logic         iSRST,
	input  logic         startStrobe,
	input  spiPkg::byteT txByteIn,
	input  spiPkg::divT  divisorIn,
	input  logic         byteDone,
	output logic         masterEnable,
	output spiPkg::byteT txByte,
	output spiPkg::divT  divisor
);

	// Start only counts when no byte is in flight
	logic startAccept;

	assign startAccept = startStrobe && !masterEnable;

	// --------------------------------------------------
	// Run enable
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			masterEnable <= 1'b0;
		end
		else if (byteDone)
		begin
			// Completion pulse drops the enable
			// Engine and divider return to idle on the next clock
			masterEnable <= 1'b0;
		end
		else if (startAccept)
		begin
			masterEnable <= 1'b1;
		end
	end

	// --------------------------------------------------
	// Transfer parameters
	// --------------------------------------------------

	// Captured with the enable so both change on the same edge
	// Stay stable for the whole byte
	always_ff @(posedge iSCLK)
	begin
		if (startAccept && !byteDone)
		begin
			txByte  <= txByteIn;
			divisor <= divisorIn;
		end
	end

endmodule

`default_nettype wire

//--- src/spiPkg.sv
/*
 * SPI unit shared types
 * Vector widths used across the master and slave paths
 * and the encoding of the master MOSI hold FSM
 */
`default_nettype none

package spiPkg;

	// --------------------------------------------------
	// Data widths
	// --------------------------------------------------

	// One byte on the master wire
	typedef logic [7:0] byteT;

	// Slave address word or data word
	typedef logic [31:0] wordT;

	// Master SCK divisor
	// Half period is divisor plus one clocks
	typedef logic [7:0] divT;

	// Register index from address bits 3:2
	typedef logic [1:0] regIdxT;

	// --------------------------------------------------
	// Master hold FSM
	// --------------------------------------------------
	typedef enum logic
	{
		holdIdle,
		holdActive
	} holdStateT;

endpackage

`default_nettype wire

//--- src/spiRegBank.sv
/*
 * Slave register bank
 * Written by slave write frames, read combinationally by address
 */
`default_nettype none
`timescale 1ns/10ps

module spiRegBank #(
	parameter int pRegCount = 4
) (
	input  logic         iSCLK,
	input  logic         iSRST,
	input  logic         writeStrobe,
	input  spiPkg::wordT regAddr,
	input  spiPkg::wordT writeData,
	output spiPkg::wordT readData
);
	import spiPkg::*;

	wordT   regs [pRegCount];
	regIdxT regIdx;
	logic   idxValid;

	// Word addressed, bits 1:0 ignored
	assign regIdx = regAddr[3:2];

	// Indexes past the bank read as zero and drop writes
	assign idxValid = int'(regIdx) < pRegCount;

	// --------------------------------------------------
	// Write port
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			for (int i = 0; i < pRegCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeStrobe && idxValid)
		begin
			regs[regIdx] <= writeData;
		end
	end

	// --------------------------------------------------
	// Read port
	// --------------------------------------------------

	// Follows regAddr directly so MISO reload sees it one clock after the latch
	assign readData = idxValid ? regs[regIdx] : '0;

endmodule

`default_nettype wire

//--- src/spiSlaveFrame.sv
/*
 * SPI slave frame engine and direction synchronizer
 * Receives 32-bit address then 32-bit data and shifts the
 * addressed register out on MISO during the data word
 */
`default_nettype none
`timescale 1ns/10ps

module spiSlaveFrame (
	input  logic         iSCLK,
	input  logic         iSRST,
	input  logic         spiDir,
	input  logic         slaveSck,
	input  logic         slaveMosi,
	input  logic         slaveCs,
	input  spiPkg::wordT readData,
	output logic         slaveMiso,
	output logic         spiDirOut,
	output logic         nSpiDirOut,
	output logic         writeStrobe,
	output spiPkg::wordT regAddr,
	output spiPkg::wordT writeData
);
	import spiPkg::*;

	logic [2:0] dirSync;
	logic       slaveMode;
	logic [2:0] sckSync;
	logic [2:0] csSync;
	logic [1:0] mosiSync;
	logic       csHigh;
	logic       riseSck;
	logic       fallSck;
	logic       wordEnd;
	logic [4:0] negCount;
	logic       dataPhase;
	logic [6:0] markDly;
	wordT       rxShift;
	wordT       misoShift;

	// --------------------------------------------------
	// Direction
	// --------------------------------------------------

	// High is FPGA slave, low is FPGA master
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			dirSync    <= 3'b111;
			nSpiDirOut <= 1'b0;
		end
		else
		begin
			dirSync    <= {dirSync[1:0], spiDir};
			nSpiDirOut <= ~dirSync[1];
		end
	end

	assign slaveMode = dirSync[2];
	assign spiDirOut = dirSync[2];

	// --------------------------------------------------
	// Pin synchronizers
	// --------------------------------------------------

	// Master mode parks the pins as an idle deselected bus
	// MOSI runs one stage short to line up with the SCK edge detect
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || !slaveMode)
		begin
			sckSync  <= 3'b000;
			csSync   <= 3'b111;
			mosiSync <= 2'b00;
		end
		else
		begin
			sckSync  <= {sckSync[1:0], slaveSck};
			csSync   <= {csSync[1:0], slaveCs};
			mosiSync <= {mosiSync[0], slaveMosi};
		end
	end

	assign csHigh  = csSync[2];
	assign riseSck = !csHigh && (sckSync[2:1] == 2'b01);
	assign fallSck = !csHigh && (sckSync[2:1] == 2'b10);
	// 32nd falling edge of either word
	assign wordEnd = fallSck && (negCount == 5'd31);

	// --------------------------------------------------
	// Frame state
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || csHigh)
		begin
			negCount  <= 5'd0;
			dataPhase <= 1'b0;
			markDly   <= 7'd0;
			regAddr   <= '0;
		end
		else
		begin
			if (fallSck)
			begin
				negCount <= negCount + 5'd1;
			end
			// Address word complete
			if (wordEnd && !dataPhase)
			begin
				dataPhase <= 1'b1;
				regAddr   <= rxShift;
			end
			// Gives readData time to settle before MISO shifts
			markDly <= {markDly[5:0], dataPhase};
		end
	end

	// Receive shift, MSB first
	always_ff @(posedge iSCLK)
	begin
		if (riseSck)
		begin
			rxShift <= {rxShift[30:0], mosiSync[1]};
		end
	end

	// Data word still sits in rxShift when the strobe fires
	assign writeData = rxShift;

	// Write on the 64th falling edge with address bit 30
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			writeStrobe <= 1'b0;
		end
		else
		begin
			writeStrobe <= wordEnd && dataPhase && regAddr[30];
		end
	end

	// --------------------------------------------------
	// MISO
	// --------------------------------------------------

	// Reload until the delayed marker then shift on falling edges
	always_ff @(posedge iSCLK)
	begin
		if (!markDly[6])
		begin
			misoShift <= readData;
		end
		else if (fallSck)
		begin
			misoShift <= {misoShift[30:0], 1'b1};
		end
	end

	assign slaveMiso = misoShift[31];

endmodule

`default_nettype wire

//--- src/spiUnit.sv
/*
 * SPI unit top level
 * Byte master and 64-bit frame slave with shared direction control
 */
`default_nettype none
`timescale 1ns/10ps

module spiUnit #(
	parameter int pHoldCycles = 2,
	parameter int pRegCount   = 4
) (
	input  logic         iSCLK,
	input  logic         iSRST,
	input  logic         spiDir,
	input  logic         slaveSck,
	input  logic         slaveMosi,
	input  logic         slaveCs,
	input  logic         masterMiso,
	input  logic         startStrobe,
	input  spiPkg::byteT txByteIn,
	input  spiPkg::divT  divisorIn,
	input  logic         masterCsLevel,
	output logic         slaveMiso,
	output logic         masterSck,
	output logic         masterMosi,
	output logic         masterCs,
	output logic         spiDirOut,
	output logic         nSpiDirOut,
	output logic         byteDone,
	output spiPkg::byteT rxByte,
	output logic         writeStrobe
);
	import spiPkg::*;

	// Master side
	logic masterEnable;
	byteT txByte;
	divT  divisor;
	logic divTick;

	// Slave side
	wordT regAddr;
	wordT writeData;
	wordT readData;

	// Chip select is driven by the host controller
	assign masterCs = masterCsLevel;

	// --------------------------------------------------
	// Master path
	// --------------------------------------------------
	spiMasterCsr i_spiMasterCsr (
		.iSCLK        (iSCLK),
		.iSRST        (iSRST),
		.startStrobe  (startStrobe),
		.txByteIn     (txByteIn),
		.divisorIn    (divisorIn),
		.byteDone     (byteDone),
		.masterEnable (masterEnable),
		.txByte       (txByte),
		.divisor      (divisor)
	);

	spiClockDivider i_spiClockDivider (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.enable  (masterEnable),
		.divisor (divisor),
		.divTick (divTick)
	);

	spiMasterByte #(
		.pHoldCycles (pHoldCycles)
	) i_spiMasterByte (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.enable   (masterEnable),
		.divTick  (divTick),
		.txByte   (txByte),
		.miso     (masterMiso),
		.sck      (masterSck),
		.mosi     (masterMosi),
		.byteDone (byteDone),
		.rxByte   (rxByte)
	);

	// --------------------------------------------------
	// Slave path
	// --------------------------------------------------
	spiSlaveFrame i_spiSlaveFrame (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.spiDir      (spiDir),
		.slaveSck    (slaveSck),
		.slaveMosi   (slaveMosi),
		.slaveCs     (slaveCs),
		.readData    (readData),
		.slaveMiso   (slaveMiso),
		.spiDirOut   (spiDirOut),
		.nSpiDirOut  (nSpiDirOut),
		.writeStrobe (writeStrobe),
		.regAddr     (regAddr),
		.writeData   (writeData)
	);

	spiRegBank #(
		.pRegCount (pRegCount)
	) i_spiRegBank (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.writeStrobe (writeStrobe),
		.regAddr     (regAddr),
		.writeData   (writeData),
		.readData    (readData)
	);

endmodule

`default_nettype wire

//--- testbench/spiUnitChecker.sv
/*
 * SPI unit protocol checker
 * Pulse width, idle SCK and direction output rules, bound into spiUnit
 */
`default_nettype none
`timescale 1ns/10ps

module spiUnitChecker (
	input logic iSCLK,
	input logic iSRST,
	input logic byteDone,
	input logic writeStrobe,
	input logic masterEnable,
	input logic masterSck,
	input logic spiDirOut,
	input logic nSpiDirOut
);

	// Failure count, read by the testbench at the end of the run
	int assertFails = 0;

	// --------------------------------------------------
	// Single-cycle pulses
	// --------------------------------------------------
	byteDonePulse: assert property (@(posedge iSCLK) disable iff (iSRST)
		byteDone |=> !byteDone)
	else
	begin
		$error("byteDone high for more than one clock");
		assertFails++;
	end

	writeStrobePulse: assert property (@(posedge iSCLK) disable iff (iSRST)
		writeStrobe |=> !writeStrobe)
	else
	begin
		$error("writeStrobe high for more than one clock");
		assertFails++;
	end

	// --------------------------------------------------
	// Master idle and direction outputs
	// --------------------------------------------------
	sckIdleLow: assert property (@(posedge iSCLK) disable iff (iSRST)
		!masterEnable |-> !masterSck)
	else
	begin
		$error("master SCK high while the master is disabled");
		assertFails++;
	end

	// Both outputs settle from the same synchronizer stage
	dirInverse: assert property (@(posedge iSCLK) disable iff (iSRST)
		$stable(spiDirOut) |-> (nSpiDirOut == !spiDirOut))
	else
	begin
		$error("nSpiDirOut is not the inverse of spiDirOut");
		assertFails++;
	end

endmodule

bind spiUnit spiUnitChecker i_spiUnitChecker (
	.iSCLK        (iSCLK),
	.iSRST        (iSRST),
	.byteDone     (byteDone),
	.writeStrobe  (writeStrobe),
	.masterEnable (masterEnable),
	.masterSck    (masterSck),
	.spiDirOut    (spiDirOut),
	.nSpiDirOut   (nSpiDirOut)
);

`default_nettype wire

//--- testbench/spiUnitTb.sv
/*
 * SPI unit testbench
 * Master bytes looped back MOSI to MISO, slave frames from a bit-banged host
 */
`default_nettype none
`timescale 1ns/10ps

module spiUnitTb;
	import spiPkg::*;

	// Host SCK half period in clocks
	localparam int lpHostHalf   = 6;
	localparam int lpNumTests   = 13;
	localparam int lpHoldCycles = 2;
	localparam int lpRegCount   = 4;

	typedef enum int
	{
		masterByte,
		slaveWrite,
		slaveRead,
		slaveGated
	} kindT;

	// One stimulus row
	typedef struct
	{
		kindT kind;
		divT  div;
		wordT addr;
		wordT data;
		wordT expVal;
	} testEntryT;

	logic iSCLK;
	logic iSRST;
	logic spiDir;
	logic slaveSck;
	logic slaveMosi;
	logic slaveCs;
	logic masterMiso;
	logic startStrobe;
	byteT txByteIn;
	divT  divisorIn;
	logic masterCsLevel;
	logic slaveMiso;
	logic masterSck;
	logic masterMosi;
	logic masterCs;
	logic spiDirOut;
	logic nSpiDirOut;
	logic byteDone;
	byteT rxByte;
	logic writeStrobe;

	testEntryT testTable [lpNumTests];
	int        errorCount  = 0;
	int        failedTests = 0;
	int        strobeCount = 0;
	int        doneCount   = 0;
	int        cycleCount  = 0;
	int        cycleLimit  = 0;

	// Loopback on the master pins
	assign masterMiso = masterMosi;

	spiUnit #(
		.pHoldCycles (lpHoldCycles),
		.pRegCount   (lpRegCount)
	) i_spiUnit (
		.iSCLK         (iSCLK),
		.iSRST         (iSRST),
		.spiDir        (spiDir),
		.slaveSck      (slaveSck),
		.slaveMosi     (slaveMosi),
		.slaveCs       (slaveCs),
		.masterMiso    (masterMiso),
		.startStrobe   (startStrobe),
		.txByteIn      (txByteIn),
		.divisorIn     (divisorIn),
		.masterCsLevel (masterCsLevel),
		.slaveMiso     (slaveMiso),
		.masterSck     (masterSck),
		.masterMosi    (masterMosi),
		.masterCs      (masterCs),
		.spiDirOut     (spiDirOut),
		.nSpiDirOut    (nSpiDirOut),
		.byteDone      (byteDone),
		.rxByte        (rxByte),
		.writeStrobe   (writeStrobe)
	);

	// --------------------------------------------------
	// Clock, pulse monitors, timeout
	// --------------------------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #20 iSCLK = ~iSCLK;
	end

	// Pulses counted mid-cycle, away from the driving edge
	always @(negedge iSCLK)
	begin
		if (byteDone === 1'b1)
			doneCount <= doneCount + 1;
		if (writeStrobe === 1'b1)
			strobeCount <= strobeCount + 1;
	end

	always @(posedge iSCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run exceeded %0d clock cycles", cycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic compareValues(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
			errorCount++;
		end
	endtask

	// Worst-case clocks for one row
	function automatic int entryCycles(input testEntryT e);
		if (e.kind == masterByte)
			return 16 * (int'(e.div) + 1) + 4 * (int'(e.div) + 1) + 40;
		return 64 * 2 * lpHostHalf + 4 * lpHostHalf + 60;
	endfunction

	task automatic loadTable();
		testTable[0]  = '{masterByte, 8'd0, 32'h0, 32'h0000_00A5, 32'h0000_00A5};
		testTable[1]  = '{masterByte, 8'd1, 32'h0, 32'h0000_003C, 32'h0000_003C};
		testTable[2]  = '{masterByte, 8'd3, 32'h0, 32'h0000_0096, 32'h0000_0096};
		// Write frames return the old register contents on MISO
		testTable[3]  = '{slaveWrite, 8'd0, 32'h4000_0004, 32'h1234_5678, 32'h0};
		testTable[4]  = '{slaveWrite, 8'd0, 32'h4000_0008, 32'hCAFE_F00D, 32'h0};
		testTable[5]  = '{slaveRead,  8'd0, 32'h0000_0004, 32'h0, 32'h1234_5678};
		// Data word present but bit 30 clear
		testTable[6]  = '{slaveRead,  8'd0, 32'h0000_0008, 32'hFFFF_FFFF, 32'hCAFE_F00D};
		testTable[7]  = '{slaveRead,  8'd0, 32'h0000_0008, 32'h0, 32'hCAFE_F00D};
		testTable[8]  = '{slaveGated, 8'd0, 32'h4000_0004, 32'h5555_AAAA, 32'h0};
		testTable[9]  = '{slaveRead,  8'd0, 32'h0000_0004, 32'h0, 32'h1234_5678};
		testTable[10] = '{slaveWrite, 8'd0, 32'h4000_0004, 32'h8765_4321, 32'h1234_5678};
		testTable[11] = '{slaveRead,  8'd0, 32'h0000_0004, 32'h0, 32'h8765_4321};
		testTable[12] = '{masterByte, 8'd1, 32'h0, 32'h0000_005A, 32'h0000_005A};
	endtask

	// Start one byte and wait for its completion pulse
	task automatic runMasterByte(input divT div, input byteT data, output byteT rx,
		output int lat);
		int limit;
		limit = 16 * (int'(div) + 1) + 20;
		@(posedge iSCLK);
		masterCsLevel <= 1'b0;
		startStrobe   <= 1'b1;
		txByteIn      <= data;
		divisorIn     <= div;
		lat = 0;
		while (lat < limit)
		begin
			@(posedge iSCLK);
			startStrobe <= 1'b0;
			lat++;
			@(negedge iSCLK);
			if (byteDone === 1'b1)
				break;
		end
		if (lat >= limit)
		begin
			$display("byteDone did not arrive within %0d cycles at %0t", limit, $time);
			errorCount++;
		end
		compareValues("masterCs", 32'(masterCs), 32'd0);
		rx = rxByte;
		@(posedge iSCLK);
		masterCsLevel <= 1'b1;
	endtask

	// Host side of one 64-bit frame, MISO sampled before each rising edge
	task automatic runFrame(input wordT addr, input wordT data, output wordT misoWord);
		logic [63:0] bits;
		bits     = {addr, data};
		misoWord = '0;
		@(posedge iSCLK);
		slaveCs <= 1'b0;
		for (int i = 63; i >= 0; i--)
		begin
			slaveMosi <= bits[i];
			repeat (lpHostHalf - 1) @(posedge iSCLK);
			@(negedge iSCLK);
			if (i < 32)
				misoWord = {misoWord[30:0], slaveMiso};
			@(posedge iSCLK);
			slaveSck <= 1'b1;
			repeat (lpHostHalf) @(posedge iSCLK);
			slaveSck <= 1'b0;
		end
		repeat (lpHostHalf) @(posedge iSCLK);
		slaveCs <= 1'b1;
		repeat (lpHostHalf) @(posedge iSCLK);
	endtask

	// Change direction and measure the synchronizer delay
	task automatic setDirection(input logic level);
		int lat;
		@(posedge iSCLK);
		spiDir <= level;
		lat = 0;
		while (lat < 10)
		begin
			@(posedge iSCLK);
			lat++;
			@(negedge iSCLK);
			if (spiDirOut === level)
				break;
		end
		compareValues("spiDirOut delay", 32'(lat), 32'd3);
		@(negedge iSCLK);
		compareValues("nSpiDirOut", 32'(nSpiDirOut), 32'(!level));
	endtask

	task automatic runEntry(input int idx);
		testEntryT e;
		int        errBefore;
		int        strobeBefore;
		int        doneBefore;
		int        lat;
		byteT      rx;
		wordT      misoWord;
		e            = testTable[idx];
		errBefore    = errorCount;
		strobeBefore = strobeCount;
		doneBefore   = doneCount;
		case (e.kind)
			masterByte:
			begin
				runMasterByte(e.div, byteT'(e.data), rx, lat);
				compareValues("rxByte", 32'(rx), e.expVal);
				compareValues("byteDone latency", 32'(lat), 32'(16 * (int'(e.div) + 1) + 2));
				// Window for a stray second pulse
				repeat (4 * (int'(e.div) + 1) + 4) @(posedge iSCLK);
				compareValues("byteDone pulses", 32'(doneCount - doneBefore), 32'd1);
			end
			slaveWrite, slaveRead:
			begin
				runFrame(e.addr, e.data, misoWord);
				compareValues("slave MISO word", misoWord, e.expVal);
				compareValues("writeStrobe pulses", 32'(strobeCount - strobeBefore),
					32'(e.kind == slaveWrite));
			end
			slaveGated:
			begin
				setDirection(1'b0);
				runFrame(e.addr, e.data, misoWord);
				compareValues("gated writeStrobe pulses", 32'(strobeCount - strobeBefore), 32'd0);
				setDirection(1'b1);
			end
		endcase
		if (errorCount != errBefore)
			failedTests++;
		$display("Test %0d %s %s", idx + 1, e.kind.name(),
			(errorCount == errBefore) ? "passed" : "FAILED");
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		int errBefore;
		int totalErrors;
		iSRST         <= 1'b1;
		spiDir        <= 1'b1;
		slaveSck      <= 1'b0;
		slaveMosi     <= 1'b0;
		slaveCs       <= 1'b1;
		startStrobe   <= 1'b0;
		txByteIn      <= '0;
		divisorIn     <= '0;
		masterCsLevel <= 1'b1;
		loadTable();
		// Reset, row budgets, margin
		cycleLimit = 16 + 200;
		for (int t = 0; t < lpNumTests; t++)
			cycleLimit += entryCycles(testTable[t]);

		repeat (16) @(posedge iSCLK);
		iSRST <= 1'b0;

		// Reset state
		@(negedge iSCLK);
		errBefore = errorCount;
		compareValues("spiDirOut after reset", 32'(spiDirOut), 32'd1);
		compareValues("nSpiDirOut after reset", 32'(nSpiDirOut), 32'd0);
		compareValues("masterSck after reset", 32'(masterSck), 32'd0);
		compareValues("byteDone after reset", 32'(byteDone), 32'd0);
		compareValues("writeStrobe after reset", 32'(writeStrobe), 32'd0);
		if (errorCount != errBefore)
			failedTests++;
		$display("Test 0 resetState %s", (errorCount == errBefore) ? "passed" : "FAILED");

		for (int t = 0; t < lpNumTests; t++)
			runEntry(t);

		totalErrors = errorCount + i_spiUnit.i_spiUnitChecker.assertFails;
		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			lpNumTests + 1, failedTests, errorCount, i_spiUnit.i_spiUnitChecker.assertFails);
		if (totalErrors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
